//--- bench/pmp_stim.txt
# T <test>  |  C <idx> <cfg byte>  |  A <idx> <pmpaddr>     (all hex)
# R <addr> <size> <we> <instr> <prv> <exc>   prv 0 U, 1 S, 3 M
T 1
R 00001000 2 0 0 3 0
R 00001000 2 1 0 1 1
R 00002004 0 0 1 0 1
R 00000000 4 0 0 3 0
R 00001003 7 0 0 1 1
T 2
A 0 00000400
A 1 00000800
C 1 0B
R 00001000 2 0 0 0 0
R 00001ffc 2 1 0 0 0
R 00001800 2 0 1 0 1
R 00001ff8 4 0 0 3 1
R 00002000 2 0 0 3 0
R 00002000 2 0 0 1 1
A 2 0000101F
C 2 1C
R 00004000 2 0 1 1 0
R 000040fc 2 0 0 1 1
R 000040f8 4 0 1 3 1
R 000040f0 4 0 1 0 0
T 3
A 3 00001804
C 3 13
A 4 00001803
C 4 18
R 00006010 2 1 0 0 0
R 00006014 2 0 0 0 1
R 00006010 1 0 0 1 0
R 0000600e 2 0 0 0 1
R 00006014 2 0 0 3 0
R 00006000 0 0 0 0 1
T 4
A 5 00002000
A 6 00002400
C 6 89
R 00008000 2 0 0 3 0
R 00008000 2 1 0 3 1
R 00008ffc 2 0 1 3 1
R 00008004 2 0 0 0 0
C 6 0F
R 00008000 2 1 0 3 1
A 5 00002200
R 00008100 2 1 0 3 1
A 6 00003000
R 00009000 2 1 0 3 0
A 7 00002800
C 7 93
R 0000a000 2 0 1 3 1
R 0000a000 2 1 0 3 0
A 7 00002900
R 0000a000 2 0 1 3 1
T 5
R 00001000 2 0 0 0 0
R 00001004 2 1 0 1 0
R 00001008 2 0 1 0 1
R 00004000 3 0 1 0 0
R 00004000 2 1 0 3 0
R 00004000 2 1 0 0 1
R 00006010 0 1 0 0 0
R 00008000 2 1 0 1 1
R 00003000 2 0 0 1 1
R 00003000 4 0 0 3 0
R 0000a000 2 1 0 0 0
R 0000a002 2 0 0 3 1
R 00009ffc 3 0 0 3 1
R 00001ffc 2 0 0 3 0

//--- src.f
logic/pmp_pkg.sv
logic/bus_pkg.sv
logic/pmp_csr_bank.sv
logic/pmp_access_range.sv
logic/pmp_entry.sv
logic/pmp_resolve.sv
logic/pmp_checker.sv
bench/pmp_checker_properties.sv
bench/pmp_checker_tb.sv

//--- Makefile
# Verilator simulation of the PMP checker, run from the project root
TOP := pmp_checker_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

//--- bench/pmp_checker_tb.sv
/*
 * Testbench for the PMP checker. Replays bench/pmp_stim.txt from the project
 * root and checks every result against the stim file and a reference model.
 */

`timescale 1ns/1ps

module pmp_checker_tb
  import pmp_pkg::*;
  import bus_pkg::*;
();

  localparam int PLEN    = 34;
  localparam int PMP_CNT = 8;
  localparam int CLK_NS  = 20;
  localparam int RST_CYC = 16;

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic        csr_we_i;
  logic        csr_sel_cfg_i;
  logic [2:0]  csr_idx_i;
  logic [31:0] csr_wdata_i;
  logic        req_i;
  access_t     access_i;
  logic        valid_o;
  logic        exception_o;

  pmpcfg_t     m_cfg [PMP_CNT];   // reference model state
  logic [31:0] m_addr [PMP_CNT];
  logic        exp_q [$];         // outstanding results in issue order
  int          issue_q [$];       // cycle each access was driven
  string       lines [$];
  int          cyc = 0;
  int          checks = 0;
  int          errors = 0;
  int          cur_test = -1;     // none open yet
  int          test_err0 = 0;
  int          test_acc = 0;
  int          n_tests = 0;
  logic [31:0] rng = 32'd33;

  pmp_checker #(
    .PLEN    (PLEN),
    .PMP_CNT (PMP_CNT)
  ) uut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .csr_we_i      (csr_we_i),
    .csr_sel_cfg_i (csr_sel_cfg_i),
    .csr_idx_i     (csr_idx_i),
    .csr_wdata_i   (csr_wdata_i),
    .req_i         (req_i),
    .access_i      (access_i),
    .valid_o       (valid_o),
    .exception_o   (exception_o)
  );

  always #(CLK_NS/2) clk_i = ~clk_i;
  always @(posedge clk_i) cyc <= cyc + 1;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // byte granular exception predicted from the PMP rules
  function automatic logic model_exception(input logic [33:0] addr, input logic [2:0] size,
                                           input logic we, input logic instr,
                                           input logic [1:0] prv);
    longint first;
    longint last;
    longint lo;
    longint hi;
    longint span;
    int     ones;
    logic   allowed;
    first = longint'(addr);
    case (size)
      3'd1:    last = first + 1;
      3'd2:    last = first + 3;
      3'd3:    last = first + 7;
      3'd4:    last = first + 15;
      default: last = first;  // byte and the unused codes
    endcase
    for (int i = 0; i < PMP_CNT; i++) begin
      lo = longint'(m_addr[i]) * 4;
      hi = lo;
      case (m_cfg[i].a)
        TOR: begin
          hi = lo;
          lo = 0;  // entry 0 starts at zero
          if (i > 0) lo = longint'(m_addr[i-1]) * 4;
        end
        NA4: hi = lo + 4;
        NAPOT: begin
          ones = 0;
          while (ones < 32 && m_addr[i][ones]) ones++;
          span = longint'(1) << (ones + 3);
          lo   = lo & ~(span - 1);
          hi   = lo + span;
        end
        default: ;
      endcase
      if (m_cfg[i].a != OFF && first < hi && last >= lo) begin
        if (first < lo || last >= hi) return 1'b1;        // straddles the region
        if (!m_cfg[i].l && prv == PRV_M) return 1'b0;
        allowed = instr ? m_cfg[i].x : (we ? m_cfg[i].w : m_cfg[i].r);
        return !allowed;
      end
    end
    return prv != PRV_M;  // no match
  endfunction

  task automatic csr_write(input logic sel_cfg, input logic [2:0] idx, input logic [31:0] data);
    logic blocked;
    if (sel_cfg) begin
      if (!m_cfg[idx].l) begin  // locked cfg ignores writes
        m_cfg[idx]      = data[7:0];
        m_cfg[idx].rsvd = 2'b00;
      end
    end else begin
      blocked = m_cfg[idx].l;
      if (int'(idx) < PMP_CNT-1) begin
        blocked = blocked | (m_cfg[idx+1].l && m_cfg[idx+1].a == TOR);
      end
      if (!blocked) m_addr[idx] = data;
    end
    csr_we_i      = 1'b1;
    csr_sel_cfg_i = sel_cfg;
    csr_idx_i     = idx;
    csr_wdata_i   = data;
    @(negedge clk_i);
    csr_we_i = 1'b0;
  endtask

  task automatic run_access(input logic [33:0] addr, input logic [2:0] size, input logic we,
                            input logic instr, input logic [1:0] prv, input logic exp);
    int gap;
    check_eq(64'(model_exception(addr, size, we, instr, prv)), 64'(exp), "model vs stim");
    exp_q.push_back(exp);
    issue_q.push_back(cyc);
    req_i          = 1'b1;
    access_i.addr  = addr;
    access_i.size  = xfer_size_t'(size);
    access_i.we    = we;
    access_i.instr = instr;
    access_i.prv   = prv_t'(prv);
    @(negedge clk_i);
    req_i = 1'b0;
    test_acc++;
    rng = xorshift32(rng);
    gap = int'(rng[1:0]);                 // 0 to 3 idle cycles
    if (cur_test == 5 && rng[2]) gap = 0; // back to back to fill the pipe
    repeat (gap) @(negedge clk_i);
  endtask

  // drain outstanding results and report the open test
  task automatic close_test();
    int errs;
    while (exp_q.size() != 0) @(negedge clk_i);
    if (cur_test >= 0) begin
      errs = errors - test_err0;
      n_tests++;
      if (errs == 0) begin
        $display("test %0d: %0d accesses, ok", cur_test, test_acc);
      end else begin
        $display("test %0d: %0d accesses, %0d errors", cur_test, test_acc, errs);
      end
    end
  endtask

  ////////////////////////////////////////
  // result monitor
  ////////////////////////////////////////

  // request driven after edge k is sampled at edge k+1 and registered out at k+2
  always @(negedge clk_i) begin
    if (!reset_i && valid_o) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("result pulse at %0t with no access outstanding", $time);
      end else begin
        check_eq(64'(exception_o), 64'(exp_q.pop_front()), "exception_o");
        check_eq(64'(cyc - issue_q.pop_front()), 64'd2, "result latency in edges");
      end
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : main
    int          fd;
    int          limit;
    int          n;
    string       line;
    byte         kind;
    logic [63:0] f0;
    logic [63:0] f1;
    logic [63:0] f2;
    logic [63:0] f3;
    logic [63:0] f4;
    logic [63:0] f5;
    reset_i       = 1'b1;
    csr_we_i      = 1'b0;
    csr_sel_cfg_i = 1'b0;
    csr_idx_i     = '0;
    csr_wdata_i   = '0;
    req_i         = 1'b0;
    access_i      = '0;
    foreach (m_cfg[i]) begin
      m_cfg[i]  = '0;  // all OFF after reset
      m_addr[i] = '0;
    end
    fd = $fopen("bench/pmp_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/pmp_stim.txt, nothing was run");
      $display("Test failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) lines.push_back(line);
      end
      $fclose(fd);

      // ten cycles per stim line plus reset
      limit = (lines.size() * 10 + RST_CYC) * CLK_NS;
      fork
        begin
          #(limit);
          $display("timed out after %0d ns, results stopped arriving", limit);
          $display("Test failed");
          $finish;
        end
      join_none

      repeat (RST_CYC) @(negedge clk_i);
      reset_i = 1'b0;

      foreach (lines[k]) begin
        line = lines[k];
        kind = line.getc(0);
        n    = $sscanf(line.substr(1, line.len()-1), "%h %h %h %h %h %h",
                       f0, f1, f2, f3, f4, f5);
        case (kind)
          "T": begin
            close_test();
            cur_test  = int'(f0);
            test_err0 = errors;
            test_acc  = 0;
          end
          "C": csr_write(1'b1, f0[2:0], f1[31:0]);
          "A": csr_write(1'b0, f0[2:0], f1[31:0]);
          "R": begin
            if (n < 6) begin
              errors++;
              $display("stim line %0d is missing fields", k+1);
            end else begin
              run_access(f0[33:0], f1[2:0], f2[0], f3[0], f4[1:0], f5[0]);
            end
          end
          default: ;  // comments and blank lines
        endcase
      end
      close_test();

      $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
      if (errors == 0 && checks > 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

//--- bench/pmp_checker_properties.sv
/*
 * Concurrent checks on the PMP checker top, attached with bind.
 * Result timing, exception qualification, reset and pmpcfg lock.
 */

`timescale 1ns/1ps

module pmp_checker_properties
  import pmp_pkg::*;
#(
  parameter  int PMP_CNT = 8,
  localparam int IDX_W   = (PMP_CNT > 1) ? $clog2(PMP_CNT) : 1
) (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  req_i,
  input logic                  valid_i,      // checker valid_o
  input logic                  exception_i,  // checker exception_o
  input logic                  csr_we_i,
  input logic                  csr_sel_cfg_i,
  input logic [IDX_W-1:0]      csr_idx_i,
  input pmpcfg_t [PMP_CNT-1:0] cfg_i         // bank registers
);

  // fixed two cycle latency, no results without a request
  a_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i == $past(req_i, 2))
    else $error("valid_o does not follow req_i by two cycles");

  a_exc_valid: assert property (@(posedge clk_i) exception_i |-> valid_i)
    else $error("exception_o high without valid_o");

  a_reset: assert property (@(posedge clk_i) reset_i |=> !valid_i && !exception_i)
    else $error("valid_o or exception_o high after reset");

  // one write per cycle, so the whole array must hold
  a_cfg_lock: assert property (@(posedge clk_i) disable iff (reset_i)
    csr_we_i && csr_sel_cfg_i && cfg_i[csr_idx_i].l |=> $stable(cfg_i))
    else $error("write to a locked pmpcfg changed the bank");

endmodule

bind pmp_checker pmp_checker_properties #(
  .PMP_CNT (PMP_CNT)
) u_properties (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .req_i         (req_i),
  .valid_i       (valid_o),
  .exception_i   (exception_o),
  .csr_we_i      (csr_we_i),
  .csr_sel_cfg_i (csr_sel_cfg_i),
  .csr_idx_i     (csr_idx_i),
  .cfg_i         (pmpcfg)
);

//--- logic/pmp_checker.sv
/*
 * PMP checker top. CSR bank, range stage, entry array and resolver.
 * Results come back as a valid pulse two cycles after each request,
 * one access may enter every cycle.
 */

`timescale 1ns/1ps

module pmp_checker
  import pmp_pkg::*;
  import bus_pkg::*;
#(
  parameter  int PLEN    = 34,  // physical address width, <= PLEN_MAX
  parameter  int PMP_CNT = 8,   // number of entries
  localparam int IDX_W   = (PMP_CNT > 1) ? $clog2(PMP_CNT) : 1
) (
  input  logic             clk_i,
  input  logic             reset_i,
  // CSR write port
  input  logic             csr_we_i,
  input  logic             csr_sel_cfg_i,  // 1 pmpcfg, 0 pmpaddr
  input  logic [IDX_W-1:0] csr_idx_i,
  input  logic [PLEN-3:0]  csr_wdata_i,
  // access check
  input  logic             req_i,
  input  access_t          access_i,
  output logic             valid_o,
  output logic             exception_o
);

  pmpcfg_t [PMP_CNT-1:0]           pmpcfg;
  logic    [PMP_CNT-1:0][PLEN-3:0] pmpaddr;
  logic    [PMP_CNT-1:0][PLEN-3:0] pmpaddr_prev;  // TOR base per entry
  access_bounds_t                  bounds;        // stage one register
  logic    [PMP_CNT-1:0]           match_any;
  logic    [PMP_CNT-1:0]           match_all;

  ////////////////////////////////////////
  // configuration state
  ////////////////////////////////////////

  pmp_csr_bank #(
    .PLEN    (PLEN),
    .PMP_CNT (PMP_CNT)
  ) u_csr_bank (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .csr_we_i      (csr_we_i),
    .csr_sel_cfg_i (csr_sel_cfg_i),
    .csr_idx_i     (csr_idx_i),
    .csr_wdata_i   (csr_wdata_i),
    .cfg_o         (pmpcfg),
    .addr_o        (pmpaddr),
    .prev_addr_o   (pmpaddr_prev)
  );

  ////////////////////////////////////////
  // stage one, access bounds
  ////////////////////////////////////////

  pmp_access_range #(
    .PLEN (PLEN)
  ) u_access_range (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .access_i (access_i),
    .bounds_o (bounds)
  );

  ////////////////////////////////////////
  // stage two, match and resolve
  ////////////////////////////////////////

  for (genvar i = 0; i < PMP_CNT; i++) begin : g_entry
    pmp_entry #(
      .PLEN (PLEN)
    ) u_entry (
      .cfg_i       (pmpcfg[i]),
      .addr_i      (pmpaddr[i]),
      .prev_addr_i (pmpaddr_prev[i]),
      .bounds_i    (bounds),
      .match_any_o (match_any[i]),
      .match_all_o (match_all[i])
    );
  end

  pmp_resolve #(
    .PMP_CNT (PMP_CNT)
  ) u_resolve (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cfg_i       (pmpcfg),
    .match_any_i (match_any),
    .match_all_i (match_all),
    .bounds_i    (bounds),
    .valid_o     (valid_o),
    .exception_o (exception_o)
  );

endmodule

//--- logic/pmp_resolve.sv
/*
 * Second checker stage. Picks the lowest numbered matching entry,
 * applies the partial match, lock and rwx rules and registers the result.
 */

`timescale 1ns/1ps

module pmp_resolve
  import pmp_pkg::*;
  import bus_pkg::*;
#(
  parameter int PMP_CNT = 8
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  pmpcfg_t [PMP_CNT-1:0] cfg_i,
  input  logic    [PMP_CNT-1:0] match_any_i,
  input  logic    [PMP_CNT-1:0] match_all_i,
  input  access_bounds_t        bounds_i,
  output logic                  valid_o,      // two cycles after req_i
  output logic                  exception_o   // only with valid_o
);

  logic    hit;        // some entry matched
  logic    hit_all;    // winner covers the whole access
  pmpcfg_t hit_cfg;    // winner config
  logic    enforce;    // rwx applies
  logic    perm_fail;
  logic    fault;
  logic    valid_q;
  logic    exc_q;

  ////////////////////////////////////////
  // priority select
  ////////////////////////////////////////

  // walk down so the lowest index is the last to assign
  always_comb begin
    hit     = 1'b0;
    hit_all = 1'b0;
    hit_cfg = '0;
    for (int i = PMP_CNT-1; i >= 0; i--) begin
      if (match_any_i[i]) begin
        hit     = 1'b1;
        hit_all = match_all_i[i];
        hit_cfg = cfg_i[i];
      end
    end
  end

  ////////////////////////////////////////
  // fault decision
  ////////////////////////////////////////

  assign enforce = hit_cfg.l | (bounds_i.prv != PRV_M);  // M mode skips unlocked

  always_comb begin
    if (bounds_i.instr) begin
      perm_fail = ~hit_cfg.x;   // fetch
    end else if (bounds_i.we) begin
      perm_fail = ~hit_cfg.w;   // store
    end else begin
      perm_fail = ~hit_cfg.r;   // load
    end
  end

  // no match: only M mode passes
  // match: straddling a region boundary always faults
  assign fault = hit ? (~hit_all | (enforce & perm_fail))
                     : (bounds_i.prv != PRV_M);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      exc_q   <= 1'b0;
    end else begin
      valid_q <= bounds_i.valid;
      exc_q   <= bounds_i.valid & fault;  // never without valid
    end
  end

  assign valid_o     = valid_q;
  assign exception_o = exc_q;

endmodule

//--- logic/pmp_entry.sv
/*
 * One PMP entry. Decodes the region from mode and pmpaddr and flags
 * whether any or all words of the stage one access fall inside it.
 */

`timescale 1ns/1ps

module pmp_entry
  import pmp_pkg::*;
  import bus_pkg::*;
#(
  parameter int PLEN = 34
) (
  input  pmpcfg_t         cfg_i,
  input  logic [PLEN-3:0] addr_i,       // pmpaddr, word address
  input  logic [PLEN-3:0] prev_addr_i,  // pmpaddr of the entry below
  input  access_bounds_t  bounds_i,
  output logic            match_any_o,  // some word inside
  output logic            match_all_o   // every word inside
);

  // region and access bounds in words, two spare msbs so NAPOT
  // regions at the top of memory do not wrap
  logic [PLEN-1:0] reg_lb;   // inclusive
  logic [PLEN-1:0] reg_ub;   // exclusive
  logic [PLEN-1:0] acc_lb;
  logic [PLEN-1:0] acc_ub;   // inclusive
  logic [PLEN-1:0] napot_mask;
  logic            entry_on;
  int              ones;

  // count of ones from bit 0 up to the first zero
  function automatic int trailing_ones(logic [PLEN-3:0] a);
    int n;
    n = 0;
    for (int i = 0; i < PLEN-2; i++) begin
      if (a[i] && (n == i)) begin
        n++;
      end
    end
    return n;
  endfunction

  ////////////////////////////////////////
  // region decode
  ////////////////////////////////////////

  assign ones       = trailing_ones(addr_i);
  assign napot_mask = {PLEN{1'b1}} << (ones + 1);  // 2^(ones+3) bytes

  always_comb begin
    reg_lb = '0;
    reg_ub = '0;
    case (cfg_i.a)
      TOR: begin
        reg_lb = PLEN'(prev_addr_i);
        reg_ub = PLEN'(addr_i);   // empty if prev >= addr
      end
      NA4: begin
        reg_lb = PLEN'(addr_i);
        reg_ub = PLEN'(addr_i) + PLEN'(1);
      end
      NAPOT: begin
        reg_lb = PLEN'(addr_i) & napot_mask;
        reg_ub = (PLEN'(addr_i) & napot_mask) + (PLEN'(1) << (ones + 1));
      end
      default: ;  // OFF
    endcase
  end

  ////////////////////////////////////////
  // match
  ////////////////////////////////////////

  assign acc_lb   = PLEN'(bounds_i.lb[PLEN-3:0]);
  assign acc_ub   = PLEN'(bounds_i.ub[PLEN-3:0]);
  assign entry_on = (cfg_i.a != OFF);

  // disjoint when access starts at or above top, or ends below base
  assign match_any_o = entry_on & ~((acc_lb >= reg_ub) | (acc_ub < reg_lb));
  assign match_all_o = entry_on & (acc_lb >= reg_lb) & (acc_ub < reg_ub);

endmodule

//--- logic/pmp_access_range.sv
/*
 * First checker stage. Turns a request address and size into the
 * first and last word it touches and registers them with the attributes.
 */

`timescale 1ns/1ps

module pmp_access_range
  import bus_pkg::*;
#(
  parameter int PLEN = 34
) (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           req_i,     // access strobe
  input  access_t        access_i,
  output access_bounds_t bounds_o   // valid one cycle after req_i
);

  logic [PLEN-1:0] first_byte;
  logic [PLEN-1:0] last_byte;
  logic [4:0]      nbytes;
  access_bounds_t  bounds_d;
  access_bounds_t  bounds_q;

  // byte count of a transfer, undefined codes fall back to one byte
  function automatic logic [4:0] size_bytes(xfer_size_t size);
    case (size)
      HWORD:   return 5'd2;
      WORD:    return 5'd4;
      DWORD:   return 5'd8;
      QWORD:   return 5'd16;
      default: return 5'd1;
    endcase
  endfunction

  assign first_byte = access_i.addr[PLEN-1:0];
  assign nbytes     = size_bytes(access_i.size);
  assign last_byte  = first_byte + PLEN'(nbytes - 5'd1);  // inclusive end

  always_comb begin
    bounds_d              = '0;                     // unused upper bits stay zero
    bounds_d.valid        = req_i;
    bounds_d.lb[PLEN-3:0] = first_byte[PLEN-1:2];  // drop byte offset
    bounds_d.ub[PLEN-3:0] = last_byte[PLEN-1:2];
    bounds_d.we           = access_i.we;
    bounds_d.instr        = access_i.instr;
    bounds_d.prv          = access_i.prv;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bounds_q.valid <= 1'b0;
    end else begin
      bounds_q <= bounds_d;
    end
  end

  assign bounds_o = bounds_q;

endmodule

//--- logic/pmp_csr_bank.sv
/*
 * pmpcfg and pmpaddr register bank with the lock write rules.
 * Written through a one-cycle strobe, no read path. Also hands every entry
 * the address of the entry below it for TOR lower bounds.
 */

`timescale 1ns/1ps

module pmp_csr_bank
  import pmp_pkg::*;
#(
  parameter  int PLEN    = 34,
  parameter  int PMP_CNT = 8,
  localparam int IDX_W   = (PMP_CNT > 1) ? $clog2(PMP_CNT) : 1
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          csr_we_i,       // one cycle strobe
  input  logic                          csr_sel_cfg_i,  // 1 cfg, 0 addr
  input  logic [IDX_W-1:0]              csr_idx_i,
  input  logic [PLEN-3:0]               csr_wdata_i,    // cfg uses [7:0]
  output pmpcfg_t [PMP_CNT-1:0]         cfg_o,
  output logic    [PMP_CNT-1:0][PLEN-3:0] addr_o,       // pmpaddr, word address
  output logic    [PMP_CNT-1:0][PLEN-3:0] prev_addr_o   // TOR lower bound per entry
);

  pmpcfg_t [PMP_CNT-1:0]           cfg_q;
  logic    [PMP_CNT-1:0][PLEN-3:0] addr_q;
  logic    [PMP_CNT-1:0]           addr_lock;  // pmpaddr write blocked
  pmpcfg_t                         wr_cfg;

  ////////////////////////////////////////
  // write rules
  ////////////////////////////////////////

  // reserved field is hardwired to zero
  always_comb begin
    wr_cfg      = csr_wdata_i[7:0];
    wr_cfg.rsvd = 2'b00;
  end

  for (genvar i = 0; i < PMP_CNT; i++) begin : g_lock
    if (i < PMP_CNT-1) begin : g_mid
      // own lock, or locked TOR entry above uses this addr as its base
      assign addr_lock[i] = cfg_q[i].l | (cfg_q[i+1].l & (cfg_q[i+1].a == TOR));
    end else begin : g_last
      assign addr_lock[i] = cfg_q[i].l;  // nothing above the last entry
    end
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q  <= '0;  // all OFF and unlocked
      addr_q <= '0;
    end else if (csr_we_i) begin
      for (int i = 0; i < PMP_CNT; i++) begin
        if (csr_idx_i == IDX_W'(i)) begin  // out of range index hits nothing
          if (csr_sel_cfg_i && !cfg_q[i].l) begin
            cfg_q[i] <= wr_cfg;
          end
          if (!csr_sel_cfg_i && !addr_lock[i]) begin
            addr_q[i] <= csr_wdata_i;
          end
        end
      end
    end
  end

  assign cfg_o  = cfg_q;
  assign addr_o = addr_q;

  // entry 0 TOR starts at address zero
  assign prev_addr_o[0] = '0;
  for (genvar i = 1; i < PMP_CNT; i++) begin : g_prev
    assign prev_addr_o[i] = addr_q[i-1];
  end

endmodule

//--- logic/bus_pkg.sv
/*
 * Access request types seen by the PMP checker.
 * Transfer size codes, the raw request and the registered word bounds.
 */

package bus_pkg;
  import pmp_pkg::*;

  // widest physical address the structs can carry, modules use PLEN <= this
  localparam int unsigned PLEN_MAX = 34;

  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010,
    DWORD = 3'b011,
    QWORD = 3'b100   // codes above this count as one byte
  } xfer_size_t;

  typedef struct packed {
    logic [PLEN_MAX-1:0] addr;   // physical byte address
    xfer_size_t          size;
    logic                we;     // store
    logic                instr;  // instruction fetch
    prv_t                prv;    // effective privilege of the access
  } access_t;

  // stage one result, word granular and inclusive on both ends
  typedef struct packed {
    logic                valid;
    logic [PLEN_MAX-3:0] lb;     // first word touched
    logic [PLEN_MAX-3:0] ub;     // last word touched
    logic                we;
    logic                instr;
    prv_t                prv;
  } access_bounds_t;

endpackage

//--- logic/pmp_pkg.sv
/*
 * PMP definitions shared by the checker blocks and the testbench.
 * Privilege levels, address-match modes and the pmpcfg byte layout.
 * Import with pmp_pkg::* in the module header.
 */

package pmp_pkg;

  ////////////////////////////////////////
  // privilege levels
  ////////////////////////////////////////

  // encoding as in mstatus.mpp, 2'b10 is reserved
  typedef enum logic [1:0] {
    PRV_U = 2'b00,  // user
    PRV_S = 2'b01,  // supervisor
    PRV_M = 2'b11   // machine
  } prv_t;

  ////////////////////////////////////////
  // address-match modes (pmpcfg.A)
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    OFF   = 2'b00,  // entry disabled, never matches
    TOR   = 2'b01,  // top of range, lower bound from entry below
    NA4   = 2'b10,  // naturally aligned 4 byte region
    NAPOT = 2'b11   // naturally aligned power of two, 8 bytes and up
  } pmp_mode_t;

  ////////////////////////////////////////
  // pmpcfg entry byte
  ////////////////////////////////////////

  // msb first, same bit order as the pmpcfg CSR byte
  typedef struct packed {
    logic       l;     // lock, also enforces rwx on M mode
    logic [1:0] rsvd;  // reads as zero
    pmp_mode_t  a;     // match mode
    logic       x;     // instruction fetch allowed
    logic       w;     // store allowed
    logic       r;     // load allowed
  } pmpcfg_t;

endpackage
